//--- filelist.f
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_gate_fsm.sv
rtl/imem_latency_timer.sv
rtl/imem_store.sv
rtl/apb_fetch_regs.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
tb/fetch_tb.sv

//--- include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// datapath widths
`define FETCH_XLEN        64                    // program counter width
`define FETCH_INST_W      32                    // one instruction
`define FETCH_IMEM_AW     8                     // word index width
`define FETCH_IMEM_DEPTH  (1 << `FETCH_IMEM_AW) // 256 words of 64 bits
`define FETCH_LAT_W       4                     // latency field width
`define FETCH_RESET_LAT   4'd2                  // access latency out of reset

// apb port shape
`define FETCH_APB_AW      12
`define FETCH_APB_DW      32

// register map, byte offsets
`define FETCH_REG_CTRL    12'h000  // bit 0 run
`define FETCH_REG_LAT     12'h004  // access latency, never 0
`define FETCH_MEM_BASE    12'h800  // halves 0x800..0xffc

`endif

//--- rtl/apb_fetch_regs.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

// apb slave: ctrl and latency registers plus the instruction memory window
module apb_fetch_regs (
  input  logic                      clock,
  input  logic                      reset,
  input  fetch_pkg::apb_req_t       apb_req,
  output fetch_pkg::apb_rsp_t       apb_rsp,
  output logic                      run,
  output logic [`FETCH_LAT_W-1:0]   latency,
  output fetch_pkg::mem_wr_t        mem_wr,
  output logic [`FETCH_IMEM_AW-1:0] mem_rd_addr,
  output logic                      mem_rd_half,
  input  logic [`FETCH_INST_W-1:0]  mem_rd_data
);

  logic access;    // second apb phase
  logic is_ctrl;
  logic is_lat;
  logic is_mem;
  logic mem_rd;    // access is a memory read
  logic rd_wait;   // wait state already spent
  logic err;
  logic wr_fire;   // accepted write, ends this cycle

  //////////////////////////////////////////////////////////////////////
  // decode

  assign access  = apb_req.psel && apb_req.penable;
  assign is_ctrl = (apb_req.paddr == `FETCH_REG_CTRL);
  assign is_lat  = (apb_req.paddr == `FETCH_REG_LAT);
  assign is_mem  = (apb_req.paddr >= `FETCH_MEM_BASE)
                && (apb_req.paddr[1:0] == 2'b00);  // halves are word aligned
  assign mem_rd  = is_mem && !apb_req.pwrite;

  // rejected writes leave every register and the memory alone
  always_comb begin
    err = 1'b0;
    if (!(is_ctrl || is_lat || is_mem))
      err = 1'b1;                                  // unmapped
    else if (apb_req.pwrite && is_lat && apb_req.pwdata[`FETCH_LAT_W-1:0] == '0)
      err = 1'b1;                                  // zero latency
    else if (apb_req.pwrite && is_mem && run)
      err = 1'b1;                                  // program is live
  end

  //////////////////////////////////////////////////////////////////////
  // response

  // memory reads wait one cycle for the registered store port
  assign apb_rsp.pready  = access && (!mem_rd || rd_wait);
  assign apb_rsp.pslverr = apb_rsp.pready && err;

  always_comb begin
    apb_rsp.prdata = '0;
    if (is_ctrl)
      apb_rsp.prdata = {{(`FETCH_APB_DW-1){1'b0}}, run};
    else if (is_lat)
      apb_rsp.prdata = {{(`FETCH_APB_DW-`FETCH_LAT_W){1'b0}}, latency};
    else if (is_mem)
      apb_rsp.prdata = mem_rd_data;
  end

  always_ff @(posedge clock) begin
    if (reset)
      rd_wait <= 1'b0;
    else
      rd_wait <= access && mem_rd && !rd_wait;  // set for exactly one cycle
  end

  //////////////////////////////////////////////////////////////////////
  // registers

  assign wr_fire = apb_rsp.pready && apb_req.pwrite && !err;

  always_ff @(posedge clock) begin
    if (reset) begin
      run     <= 1'b0;
      latency <= `FETCH_RESET_LAT;
    end else if (wr_fire) begin
      if (is_ctrl)
        run <= apb_req.pwdata[0];
      if (is_lat)
        latency <= apb_req.pwdata[`FETCH_LAT_W-1:0];
    end
  end

  // memory window, word index in paddr 10..3, half in bit 2
  assign mem_wr.en   = wr_fire && is_mem;
  assign mem_wr.addr = apb_req.paddr[`FETCH_IMEM_AW+2:3];
  assign mem_wr.half = apb_req.paddr[2];
  assign mem_wr.data = apb_req.pwdata;

  assign mem_rd_addr = apb_req.paddr[`FETCH_IMEM_AW+2:3];
  assign mem_rd_half = apb_req.paddr[2];

  //////////////////////////////////////////////////////////////////////
  // protocol checks

  a_penable_psel : assert property (@(posedge clock) disable iff (reset)
    apb_req.penable |-> apb_req.psel);

  a_paddr_stable : assert property (@(posedge clock) disable iff (reset)
    (access && !apb_rsp.pready) |=> $stable(apb_req.paddr));

endmodule

//--- rtl/fetch_gate_fsm.sv
`timescale 1ns/1ps

// one instruction in flight: after a fetch, hold until writeback retires it
module fetch_gate_fsm (
  input  logic              clock,
  input  logic              reset,
  input  logic              run,          // fetch enabled by apb ctrl
  input  logic              fetch_fire,   // packet valid this cycle
  input  fetch_pkg::retire_t retire,
  output logic              fetch_allow
);

  localparam logic READY       = 1'b0;
  localparam logic WAIT_RETIRE = 1'b1;

  logic state;
  logic state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      READY: begin
        // a retire in the same cycle frees the slot at once
        if (fetch_fire && !retire.valid)
          state_nxt = WAIT_RETIRE;
      end
      WAIT_RETIRE: begin
        if (retire.valid)
          state_nxt = READY;
      end
      default: state_nxt = READY;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset)
      state <= READY;       // first fetch needs no retire
    else
      state <= state_nxt;
  end

  assign fetch_allow = (state == READY) && run;

  // the stage must only fire when this gate let it
  a_fire_in_ready : assert property (@(posedge clock) disable iff (reset)
    fetch_fire |-> (state == READY));

endmodule

//--- rtl/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  // packet handed to decode
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_INST_W-1:0] inst;
    logic [`FETCH_XLEN-1:0]   npc;   // pc + 4 of this instruction
  } fetch_packet_t;

  // taken branch from execute
  typedef struct packed {
    logic                   take_branch;
    logic [`FETCH_XLEN-1:0] target;
  } redirect_t;

  // writeback retirement, one cycle pulse
  typedef struct packed {
    logic valid;
  } retire_t;

  //////////////////////////////////////////////////////////////////////
  // memory word, seen as one raw word or as two instructions
  typedef struct packed {
    logic [`FETCH_INST_W-1:0] hi;  // pc bit 2 set
    logic [`FETCH_INST_W-1:0] lo;
  } imem_pair_t;

  typedef union packed {
    logic [2*`FETCH_INST_W-1:0] raw;
    imem_pair_t                 pair;
  } imem_word_u;

  //////////////////////////////////////////////////////////////////////
  // apb slave side
  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`FETCH_APB_AW-1:0] paddr;
    logic [`FETCH_APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`FETCH_APB_DW-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

  // one half write into the store
  typedef struct packed {
    logic                      en;
    logic [`FETCH_IMEM_AW-1:0] addr;  // word index
    logic                      half;  // 1 selects hi
    logic [`FETCH_INST_W-1:0]  data;
  } mem_wr_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

// program counter, next pc select and the fetch packet
module fetch_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fetch_allow,  // gate fsm says go
  input  logic                       mem_valid,    // memory data settled
  input  logic                       run,
  input  fetch_pkg::redirect_t       redirect,
  input  fetch_pkg::imem_word_u      fetch_word,
  output logic [`FETCH_IMEM_AW-1:0]  fetch_addr,
  output logic                       pc_load,      // restarts the latency timer
  output fetch_pkg::fetch_packet_t   f_packet
);

  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] pc_plus_4;
  logic [`FETCH_XLEN-1:0] next_pc;
  logic                   pc_en;
  logic                   run_q;      // run one cycle back
  logic                   run_rise;

  assign pc_plus_4 = pc + `FETCH_XLEN'(4);

  // a taken branch beats both the sequential pc and the stall
  assign next_pc = redirect.take_branch ? redirect.target : pc_plus_4;
  assign pc_en   = f_packet.valid || redirect.take_branch;

  always_ff @(posedge clock) begin
    if (reset)
      pc <= '0;               // boot from address 0
    else if (pc_en)
      pc <= next_pc;
  end

  //////////////////////////////////////////////////////////////////////
  // timer restart: every pc change, plus the first cycle of run

  always_ff @(posedge clock) begin
    if (reset)
      run_q <= 1'b0;
    else
      run_q <= run;
  end

  assign run_rise = run && !run_q;
  assign pc_load  = pc_en || run_rise;

  //////////////////////////////////////////////////////////////////////
  // packet

  assign fetch_addr = pc[`FETCH_IMEM_AW+2:3];  // 64-bit word holding pc

  assign f_packet.valid = fetch_allow && mem_valid;
  assign f_packet.inst  = pc[2] ? fetch_word.pair.hi : fetch_word.pair.lo;
  assign f_packet.npc   = pc_plus_4;            // travels with the instruction

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

// instruction fetch front end with its own memory and apb port
module fetch_top (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::apb_req_t      apb_req,
  output fetch_pkg::apb_rsp_t      apb_rsp,
  input  fetch_pkg::redirect_t     redirect,
  input  fetch_pkg::retire_t       retire,
  output fetch_pkg::fetch_packet_t f_packet
);

  logic                      run;
  logic [`FETCH_LAT_W-1:0]   latency;
  logic                      fetch_allow;
  logic                      mem_valid;
  logic                      pc_load;
  logic [`FETCH_IMEM_AW-1:0] fetch_addr;
  fetch_pkg::imem_word_u     fetch_word;
  fetch_pkg::mem_wr_t        mem_wr;
  logic [`FETCH_IMEM_AW-1:0] mem_rd_addr;
  logic                      mem_rd_half;
  logic [`FETCH_INST_W-1:0]  mem_rd_data;

  fetch_gate_fsm fetch_gate_fsm_i (
    .clock(clock), .reset(reset), .run(run), .fetch_fire(f_packet.valid),
    .retire(retire), .fetch_allow(fetch_allow)
  );

  imem_latency_timer imem_latency_timer_i (
    .clock(clock), .reset(reset), .start(pc_load), .latency(latency),
    .mem_valid(mem_valid)
  );

  imem_store imem_store_i (
    .clock(clock), .fetch_addr(fetch_addr), .fetch_word(fetch_word), .wr(mem_wr),
    .apb_rd_addr(mem_rd_addr), .apb_rd_half(mem_rd_half), .apb_rd_data(mem_rd_data)
  );

  apb_fetch_regs apb_fetch_regs_i (
    .clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .run(run), .latency(latency), .mem_wr(mem_wr), .mem_rd_addr(mem_rd_addr),
    .mem_rd_half(mem_rd_half), .mem_rd_data(mem_rd_data)
  );

  fetch_stage fetch_stage_i (
    .clock(clock), .reset(reset), .fetch_allow(fetch_allow), .mem_valid(mem_valid),
    .run(run), .redirect(redirect), .fetch_word(fetch_word), .fetch_addr(fetch_addr),
    .pc_load(pc_load), .f_packet(f_packet)
  );

endmodule

//--- rtl/imem_latency_timer.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

// models instruction memory access time
module imem_latency_timer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    start,      // new pc this edge
  input  logic [`FETCH_LAT_W-1:0] latency,
  output logic                    mem_valid
);

  logic [`FETCH_LAT_W-1:0] count;  // cycles left until data valid

  always_ff @(posedge clock) begin
    if (reset) begin
      count     <= '0;
      mem_valid <= 1'b0;            // nothing fetched yet
    end else if (start) begin
      count     <= latency;         // restart, even mid count
      mem_valid <= 1'b0;
    end else if (count != '0) begin
      count <= count - 1'b1;
      // last step of the countdown, data is there next cycle
      if (count == `FETCH_LAT_W'(1))
        mem_valid <= 1'b1;
    end
  end

  // a zero latency would never raise mem_valid
  a_lat_nonzero : assert property (@(posedge clock) disable iff (reset)
    start |-> (latency != '0));

endmodule

//--- rtl/imem_store.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

// instruction memory: fetch reads a whole word, apb works on 32-bit halves
module imem_store (
  input  logic                      clock,
  input  logic [`FETCH_IMEM_AW-1:0] fetch_addr,
  output fetch_pkg::imem_word_u     fetch_word,
  input  fetch_pkg::mem_wr_t        wr,
  input  logic [`FETCH_IMEM_AW-1:0] apb_rd_addr,
  input  logic                      apb_rd_half,
  output logic [`FETCH_INST_W-1:0]  apb_rd_data
);

  fetch_pkg::imem_word_u mem [`FETCH_IMEM_DEPTH];  // contents come over apb

  //////////////////////////////////////////////////////////////////////
  // fetch port

  // whole word out, the stage picks the half by pc bit 2
  assign fetch_word.raw = mem[fetch_addr].raw;

  //////////////////////////////////////////////////////////////////////
  // apb port

  // half write through the pair view
  always_ff @(posedge clock) begin
    if (wr.en) begin
      if (wr.half)
        mem[wr.addr].pair.hi <= wr.data;
      else
        mem[wr.addr].pair.lo <= wr.data;
    end
  end

  // registered read, costs the apb side one wait state
  always_ff @(posedge clock) begin
    if (apb_rd_half)
      apb_rd_data <= mem[apb_rd_addr].pair.hi;
    else
      apb_rd_data <= mem[apb_rd_addr].pair.lo;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fetch testbench with verilator, runs it and scans the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f filelist.f \
  --Mdir obj_dir -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation clean"

//--- tb/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb;

  localparam int APB_LIMIT = 8;   // cycles an apb access may stretch
  localparam int PKT_LIMIT = 64;  // cycles to wait for a fetch packet

  logic                     clock;
  logic                     reset;
  fetch_pkg::apb_req_t      apb_req;
  fetch_pkg::apb_rsp_t      apb_rsp;
  fetch_pkg::redirect_t     redirect;
  fetch_pkg::retire_t       retire;
  fetch_pkg::fetch_packet_t f_packet;

  logic [31:0] model_mem [512];  // one entry per half, indexed by pc[10:2]
  logic [63:0] model_pc;
  int          lat;              // latency register as last written
  logic        pkt_now;          // packet seen at the current falling edge
  int          errors;
  int          timeouts;

  fetch_top fetch_top_i (.clock(clock), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
                         .redirect(redirect), .retire(retire), .f_packet(f_packet));

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // cycle stepping and packet model

  // every falling edge checks whatever packet the stage shows
  task automatic fall_edge();
    @(negedge clock);
    retire.valid         = 1'b0;  // pulses cover one rising edge
    redirect.take_branch = 1'b0;
    pkt_now = f_packet.valid;
    if (pkt_now) begin
      // word pc[10:3], hi half when pc[2] is set
      check_value("f_packet.inst", model_mem[model_pc[10:2]], f_packet.inst);
      check_value("f_packet.npc", model_pc + 64'd4, f_packet.npc);
      model_pc = model_pc + 64'd4;
    end
  endtask

  task automatic next_packet(input int limit, input logic retire_now, output int cycles);
    cycles = 0;
    do begin
      fall_edge();
      cycles++;
    end while (!pkt_now && cycles < limit);
    if (!pkt_now) begin
      timeouts++;
      $display("Timeout at %0t ns: no fetch packet within %0d cycles", $time, limit);
    end
    retire.valid = retire_now && pkt_now;  // same cycle as the fetch
  endtask

  task automatic branch_to(input logic [63:0] target);
    redirect.take_branch = 1'b1;
    redirect.target      = target;
    model_pc             = target;
  endtask

  //////////////////////////////////////////////////////////////////////
  // apb master

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
    fall_edge();
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    fall_edge();
    apb_req.penable = 1'b1;  // access phase
    waits = 0;
    #1;
    while (!apb_rsp.pready && waits < APB_LIMIT) begin
      fall_edge();
      #1;
      waits++;
    end
    if (!apb_rsp.pready) begin
      timeouts++;
      $display("Timeout at %0t ns: apb access to %h never saw pready", $time, addr);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    fall_edge();
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_access(1'b1, addr, data, rdata, err, waits);
    check_value("apb_rsp.pslverr", exp_err, err);
    check_value("apb_rsp.pready wait states", 0, waits);  // writes never wait
  endtask

  task automatic reg_read(input logic [11:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_access(1'b0, addr, 32'd0, rdata, err, waits);
    check_value("apb_rsp.pslverr", exp_err, err);
    if (!exp_err)
      check_value("apb_rsp.prdata", exp, rdata);
    // memory reads spend one cycle in the registered store port
    check_value("apb_rsp.pready wait states", addr >= `FETCH_MEM_BASE, waits);
  endtask

  task automatic mem_write(input int half_idx, input logic [31:0] data);
    reg_write(`FETCH_MEM_BASE + 12'(half_idx * 4), data, 1'b0);
    model_mem[half_idx] = data;
  endtask

  task automatic set_latency(input int value);
    reg_write(`FETCH_REG_LAT, 32'(value), 1'b0);
    lat = value;
  endtask

  // data still valid from before a stop lets a packet out right after the run edge
  task automatic start_run(input logic retire_now, output int cycles);
    reg_write(`FETCH_REG_CTRL, 32'd1, 1'b0);
    cycles = 0;
    if (pkt_now)
      retire.valid = retire_now;
    else
      next_packet(PKT_LIMIT, retire_now, cycles);
  endtask

  // last packet still waits for retire, so nothing slips out while run drops
  task automatic stop_run();
    reg_write(`FETCH_REG_CTRL, 32'd0, 1'b0);
    fall_edge();
    retire.valid = 1'b1;
    fall_edge();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int          cycles;
    int          hold;
    int          idx;
    logic [63:0] target;
    void'($urandom(32'hc479_39ee));
    errors   = 0;
    timeouts = 0;
    model_pc = '0;
    lat      = `FETCH_RESET_LAT;
    pkt_now  = 1'b0;
    reset    = 1'b1;
    apb_req  = '0;
    redirect = '0;
    retire   = '0;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    check_value("f_packet.valid", 0, f_packet.valid);
    check_value("apb_rsp.pready", 0, apb_rsp.pready);
    reg_read(`FETCH_REG_CTRL, 32'd0, 1'b0);
    reg_read(`FETCH_REG_LAT, lat, 1'b0);

    // load every half, scatter more writes, read back
    for (int i = 0; i < 512; i++)
      mem_write(i, $urandom);
    repeat (64) mem_write($urandom % 512, $urandom);
    repeat (64) begin
      idx = $urandom % 512;
      reg_read(`FETCH_MEM_BASE + 12'(idx * 4), model_mem[idx], 1'b0);
    end

    // sequential fetch from pc 0, 60 packets
    set_latency(1 + $urandom % 4);
    start_run(1'b0, cycles);
    check_value("cycles from run to first packet", lat + 1, cycles);  // run edge, then L
    for (int n = 1; n < 60; n++) begin
      if ($urandom % 2) begin
        fall_edge();                                  // retire one cycle late
        check_value("f_packet.valid while stalled", 0, pkt_now);
      end
      retire.valid = 1'b1;
      next_packet(PKT_LIMIT, 1'b0, cycles);
    end
    stop_run();

    // one in flight while retire is held back
    start_run(1'b0, cycles);
    repeat (8) begin
      hold = lat + 1 + $urandom % 16;
      repeat (hold) begin
        fall_edge();
        check_value("f_packet.valid while stalled", 0, pkt_now);
      end
      retire.valid = 1'b1;
      next_packet(PKT_LIMIT, 1'b0, cycles);
      check_value("cycles from retire to packet", 1, cycles);  // latency already spent
    end
    stop_run();

    // gap between packets set by the latency register
    repeat (6) begin
      set_latency(1 + $urandom % 15);
      start_run(1'b1, cycles);
      for (int n = 1; n < 5; n++) begin
        next_packet(PKT_LIMIT, n < 4, cycles);
        check_value("cycles between packets", lat + 1, cycles);  // fetch edge, then L
      end
      stop_run();
    end

    // taken branches during a stall and next to a fetch
    start_run(1'b0, cycles);
    for (int n = 0; n < 8; n++) begin
      target = {$urandom, $urandom} & ~64'd3;
      if (n % 2) begin
        repeat (1 + $urandom % 4) fall_edge();
        branch_to(target);   // pc moves although the slot is taken
        fall_edge();
        retire.valid = 1'b1;
      end else begin
        retire.valid = 1'b1;  // fetch, retire and branch on one edge
        branch_to(target);
      end
      next_packet(PKT_LIMIT, 1'b0, cycles);
    end
    stop_run();

    // rejected accesses change nothing
    reg_read(12'h008, 32'd0, 1'b1);
    reg_write(12'h100, 32'd1, 1'b1);
    reg_write(`FETCH_MEM_BASE + 12'h2, 32'hdead_beef, 1'b1);  // misaligned half
    reg_write(`FETCH_REG_LAT, 32'd0, 1'b1);
    reg_read(`FETCH_REG_LAT, lat, 1'b0);
    reg_read(`FETCH_REG_CTRL, 32'd0, 1'b0);
    start_run(1'b0, cycles);
    idx = model_pc[10:2];  // half the next fetch reads
    reg_write(`FETCH_MEM_BASE + 12'(idx * 4), ~model_mem[idx], 1'b1);
    reg_read(`FETCH_REG_CTRL, 32'd1, 1'b0);
    stop_run();
    reg_read(`FETCH_MEM_BASE + 12'(idx * 4), model_mem[idx], 1'b0);
    start_run(1'b0, cycles);  // pc and memory as they were
    stop_run();

    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
